//--- src/memCtrlPkg.sv
package memCtrlPkg;

    // address and data widths
    localparam int AddrWidth = 32;
    localparam int WordWidth = 32;
    localparam int ByteWidth = 8;

    // bytes in a fetch and in the widest data access
    localparam int BytesPerWord = 4;

    localparam int LenWidth = 3;
    localparam int StageWidth = 3;

    typedef logic [AddrWidth-1:0] addrT;
    typedef logic [WordWidth-1:0] wordT;
    typedef logic [ByteWidth-1:0] byteT;

    // access length in bytes, legal values 1, 2 and 4
    typedef logic [LenWidth-1:0] lenT;

    // byte index inside a transfer, 0 through 4
    typedef logic [StageWidth-1:0] stageT;

    // which side owns the RAM port
    typedef enum logic [1:0] {
        ownerNone  = 2'd0,
        ownerData  = 2'd1,
        ownerFetch = 2'd2
    } ownerT;

endpackage

//--- src/memXferIf.sv
`timescale 1ns/1ps

interface memXferIf import memCtrlPkg::*; ();

    // request side, latched by the arbiter
    logic  start;
    ownerT owner;
    logic  isWrite;
    addrT  baseAddr;
    lenT   len;
    wordT  writeWord;

    // progress of the transfer
    stageT stage;
    logic  capture;
    logic  last;

    modport arbiter (
        output start, owner, isWrite, baseAddr, len, writeWord,
        input  last
    );

    modport sequencer (
        input  start, isWrite, baseAddr, len, writeWord,
        output stage, capture, last
    );

    modport response (
        input owner, isWrite, len, stage, capture, last
    );

endinterface

//--- src/memArbiter.sv
`timescale 1ns/1ps

module memArbiter import memCtrlPkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     rdy,

    input  logic     fetchEn,
    input  addrT     fetchAddr,

    input  logic     dataEn,
    input  logic     dataWrite,
    input  lenT      dataLen,
    input  addrT     dataAddr,
    input  wordT     dataWData,

    memXferIf.arbiter xfer,

    output ownerT    owner
);

    ownerT ownerQ;
    logic  startQ;
    // quiet done cycle after each transfer
    logic  ended;
    logic  idle;
    logic  grantData;
    logic  grantFetch;

    assign idle       = (ownerQ == ownerNone) && !ended;
    assign grantData  = idle && dataEn;
    assign grantFetch = idle && !dataEn && fetchEn;

    always_ff @(posedge clk) begin
        if (rst) begin
            ownerQ <= ownerNone;
            startQ <= 1'b0;
            ended  <= 1'b0;
        end else if (rdy) begin
            startQ <= 1'b0;
            ended  <= 1'b0;
            if (xfer.last) begin
                ownerQ <= ownerNone;
                ended  <= 1'b1;
            end else if (grantData) begin
                ownerQ <= ownerData;
                startQ <= 1'b1;
            end else if (grantFetch) begin
                ownerQ <= ownerFetch;
                startQ <= 1'b1;
            end
        end
    end

    // request fields stay put for the whole transfer
    always_ff @(posedge clk) begin
        if (rdy && grantData) begin
            xfer.isWrite   <= dataWrite;
            xfer.len       <= dataLen;
            xfer.baseAddr  <= dataAddr;
            xfer.writeWord <= dataWData;
        end else if (rdy && grantFetch) begin
            // a fetch is a plain four-byte read
            xfer.isWrite   <= 1'b0;
            xfer.len       <= lenT'(BytesPerWord);
            xfer.baseAddr  <= fetchAddr;
            xfer.writeWord <= '0;
        end
    end

    assign xfer.start = startQ;
    assign xfer.owner = ownerQ;
    assign owner      = ownerQ;

    // the sequencer only finishes a transfer that was granted
    lastWhileOwned: assert property (@(posedge clk) disable iff (rst)
        xfer.last |-> ownerQ != ownerNone);

endmodule

//--- src/byteSequencer.sv
`timescale 1ns/1ps

module byteSequencer import memCtrlPkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       rdy,

    memXferIf.sequencer xfer,

    output addrT       memAddr,
    output logic       memWrite,
    output byteT       memWData
);

    stageT stageQ;
    logic  busy;
    logic  active;
    logic  finalStage;

    // start covers stage 0 and busy the rest
    assign active = xfer.start || busy;

    // reads need one extra stage for the last byte to come back
    always_comb begin
        if (xfer.isWrite) begin
            finalStage = (stageQ == xfer.len - 3'd1);
        end else begin
            finalStage = (stageQ == xfer.len);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stageQ <= '0;
            busy   <= 1'b0;
        end else if (rdy && active) begin
            if (finalStage) begin
                stageQ <= '0;
                busy   <= 1'b0;
            end else begin
                stageQ <= stageQ + 3'd1;
                busy   <= 1'b1;
            end
        end
    end

    assign xfer.stage   = stageQ;
    assign xfer.last    = active && finalStage;
    assign xfer.capture = active && !xfer.isWrite && (stageQ != '0);

    // address walks up from the base and rests at zero
    assign memAddr  = active ? xfer.baseAddr + addrT'(stageQ) : '0;
    assign memWrite = active && xfer.isWrite;
    assign memWData = xfer.writeWord[ByteWidth*stageQ[1:0] +: ByteWidth];

    writeInRange: assert property (@(posedge clk) disable iff (rst)
        memWrite |-> stageQ < xfer.len);

    stageBounded: assert property (@(posedge clk) disable iff (rst)
        stageQ <= BytesPerWord);

endmodule

//--- src/memResponse.sv
`timescale 1ns/1ps

module memResponse import memCtrlPkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      rdy,

    memXferIf.response xfer,

    input  byteT      memRData,

    output logic      fetchDone,
    output wordT      fetchInst,
    output logic      dataDone,
    output wordT      loadData
);

    // the RAM answers one cycle later even during a stall,
    // so the byte is held until the transfer moves again
    logic  rdyQ;
    byteT  heldByte;
    byteT  byteIn;
    stageT laneStage;
    wordT  gathered;
    wordT  merged;
    wordT  keepMask;

    assign byteIn    = rdyQ ? memRData : heldByte;
    assign laneStage = xfer.stage - 3'd1;

    always_comb begin
        merged = gathered;
        if (xfer.capture) begin
            merged[ByteWidth*laneStage[1:0] +: ByteWidth] = byteIn;
        end
    end

    // zero extension for short loads
    always_comb begin
        case (xfer.len)
            3'd1:    keepMask = 32'h0000_00ff;
            3'd2:    keepMask = 32'h0000_ffff;
            default: keepMask = 32'hffff_ffff;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rdyQ <= 1'b0;
        end else begin
            rdyQ <= rdy;
        end
    end

    always_ff @(posedge clk) begin
        heldByte <= byteIn;
        if (rdy && xfer.capture) begin
            gathered <= merged;
        end
        if (rdy && xfer.last && !xfer.isWrite) begin
            if (xfer.owner == ownerFetch) begin
                fetchInst <= merged;
            end else begin
                loadData <= merged & keepMask;
            end
        end
    end

    // done pulses one cycle after last
    always_ff @(posedge clk) begin
        if (rst) begin
            fetchDone <= 1'b0;
            dataDone  <= 1'b0;
        end else if (rdy) begin
            fetchDone <= xfer.last && (xfer.owner == ownerFetch);
            dataDone  <= xfer.last && (xfer.owner == ownerData);
        end
    end

    // returned bytes land inside an owned access
    captureInRange: assert property (@(posedge clk) disable iff (rst)
        xfer.capture |-> xfer.owner != ownerNone && xfer.stage <= xfer.len);

endmodule

//--- src/memCtrl.sv
`timescale 1ns/1ps

module memCtrl import memCtrlPkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  rdy,

    // instruction fetch
    input  logic  fetchEn,
    input  addrT  fetchAddr,
    output logic  fetchDone,
    output wordT  fetchInst,

    // data side
    input  logic  dataEn,
    input  logic  dataWrite,
    input  lenT   dataLen,
    input  addrT  dataAddr,
    input  wordT  dataWData,
    output logic  dataDone,
    output wordT  loadData,

    // byte-wide RAM
    input  byteT  memRData,
    output addrT  memAddr,
    output logic  memWrite,
    output byteT  memWData,

    output ownerT owner
);

    memXferIf xfer ();

    memArbiter i_memArbiter (
        .clk       (clk),
        .rst       (rst),
        .rdy       (rdy),
        .fetchEn   (fetchEn),
        .fetchAddr (fetchAddr),
        .dataEn    (dataEn),
        .dataWrite (dataWrite),
        .dataLen   (dataLen),
        .dataAddr  (dataAddr),
        .dataWData (dataWData),
        .xfer      (xfer.arbiter),
        .owner     (owner)
    );

    byteSequencer i_byteSequencer (
        .clk      (clk),
        .rst      (rst),
        .rdy      (rdy),
        .xfer     (xfer.sequencer),
        .memAddr  (memAddr),
        .memWrite (memWrite),
        .memWData (memWData)
    );

    memResponse i_memResponse (
        .clk       (clk),
        .rst       (rst),
        .rdy       (rdy),
        .xfer      (xfer.response),
        .memRData  (memRData),
        .fetchDone (fetchDone),
        .fetchInst (fetchInst),
        .dataDone  (dataDone),
        .loadData  (loadData)
    );

endmodule

//--- test/byteRamModel.sv
`timescale 1ns/1ps

module byteRamModel import memCtrlPkg::*; (
    input  logic clk,
    input  addrT addr,
    input  logic write,
    input  byteT wdata,
    output byteT rdata
);

    localparam int IndexBits = 10;
    localparam int Bytes = 1 << IndexBits;

    byteT                 mem [Bytes];
    logic [IndexBits-1:0] index;

    // upper address bits wrap onto the small array
    assign index = addr[IndexBits-1:0];

    // read data shows up one cycle after the address
    always @(posedge clk) begin
        rdata <= mem[index];
        if (write) begin
            mem[index] <= wdata;
        end
    end

    // known pattern, every address bit feeds the byte
    task automatic preload();
        int unsigned a;
        for (a = 0; a < Bytes; a++) begin
            mem[a] = byteT'((a * 37) ^ (a >> 3) ^ 32'ha5);
        end
    endtask

endmodule

//--- test/memCtrlTb.sv
`timescale 1ns/1ps

module memCtrlTb import memCtrlPkg::*; ();

    localparam int ResetCycles = 16;
    localparam int NumRows = 14;
    localparam int RamBytes = 1024;
    localparam int GapCycles = 96;
    localparam int RowCycles = 12;

    typedef struct packed {
        logic useFetch;
        logic useData;
        logic write;
        lenT  len;
        addrT dAddr;
        addrT fAddr;
        wordT wdata;
        wordT expData;
        wordT expFetch;
    } rowT;

    logic  clk;
    logic  rst;
    logic  rdy;
    logic  fetchEn;
    addrT  fetchAddr;
    logic  dataEn;
    logic  dataWrite;
    lenT   dataLen;
    addrT  dataAddr;
    wordT  dataWData;
    byteT  memRData;
    addrT  memAddr;
    logic  memWrite;
    byteT  memWData;
    ownerT owner;
    logic  fetchDone;
    wordT  fetchInst;
    logic  dataDone;
    wordT  loadData;

    rowT  rows [NumRows];
    byteT shadow [RamBytes];
    wordT gapFreeLoad [NumRows];
    wordT gapFreeInst [NumRows];
    logic gapPattern [GapCycles];
    int   gapPos;
    int   stallCycles;
    int   errors;
    int   failedRows;
    int   rowsRun;
    bit   rowBad;
    int   curRow;
    int   cycleCount;
    int   cycleLimit;

    memCtrl i_memCtrl (
        .clk       (clk),
        .rst       (rst),
        .rdy       (rdy),
        .fetchEn   (fetchEn),
        .fetchAddr (fetchAddr),
        .fetchDone (fetchDone),
        .fetchInst (fetchInst),
        .dataEn    (dataEn),
        .dataWrite (dataWrite),
        .dataLen   (dataLen),
        .dataAddr  (dataAddr),
        .dataWData (dataWData),
        .dataDone  (dataDone),
        .loadData  (loadData),
        .memRData  (memRData),
        .memAddr   (memAddr),
        .memWrite  (memWrite),
        .memWData  (memWData),
        .owner     (owner)
    );

    byteRamModel i_byteRamModel (
        .clk   (clk),
        .addr  (memAddr),
        .write (memWrite),
        .wdata (memWData),
        .rdata (memRData)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("timeout after %0d cycles, no done pulse arrived in row %0d",
                cycleCount, curRow);
            $display("Test failures found");
            $finish;
        end
    end

    task automatic compareWord(input string name, input wordT got, input wordT exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
            errors++;
            rowBad = 1'b1;
        end
    endtask

    task automatic ownerIs(input string name, input ownerT got, input ownerT exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
            errors++;
            rowBad = 1'b1;
        end
    endtask

    task automatic doneOrder(input int dataAt, input int fetchAt);
        if (!(dataAt >= 0 && dataAt < fetchAt)) begin
            $display("FAILED at %0t ns: done order got dataDone at %0d fetchDone at %0d",
                $time, dataAt, fetchAt);
            errors++;
            rowBad = 1'b1;
        end
    endtask

    task automatic countIs(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("FAILED at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
            errors++;
            rowBad = 1'b1;
        end
    endtask

    function automatic byteT patternByte(input int unsigned a);
        return byteT'((a * 37) ^ (a >> 3) ^ 32'ha5);
    endfunction

    // gap-free pass keeps rdy high
    function automatic logic nextRdy(input int pass);
        if (pass == 0 || gapPos >= GapCycles) begin
            return 1'b1;
        end
        gapPos = gapPos + 1;
        return gapPattern[gapPos-1];
    endfunction

    task automatic setRow(input int i, input logic f, input logic d, input logic wr,
                          input lenT len, input addrT dA, input addrT fA);
        rows[i] = '0;
        rows[i].useFetch = f;
        rows[i].useData = d;
        rows[i].write = wr;
        rows[i].len = len;
        rows[i].dAddr = dA;
        rows[i].fAddr = fA;
        rows[i].wdata = wr ? wordT'($urandom) : '0;
    endtask

    // walk the table over a shadow RAM, data side before fetch
    task automatic computeExpected();
        int   i;
        int   k;
        wordT w;
        for (k = 0; k < RamBytes; k++) begin
            shadow[k] = patternByte(k);
        end
        for (i = 0; i < NumRows; i++) begin
            if (rows[i].useData && rows[i].write) begin
                for (k = 0; k < rows[i].len; k++) begin
                    shadow[(rows[i].dAddr + k) % RamBytes] = rows[i].wdata[8*k +: 8];
                end
            end else if (rows[i].useData) begin
                w = '0;
                for (k = 0; k < rows[i].len; k++) begin
                    w[8*k +: 8] = shadow[(rows[i].dAddr + k) % RamBytes];
                end
                rows[i].expData = w;
            end
            if (rows[i].useFetch) begin
                for (k = 0; k < BytesPerWord; k++) begin
                    w[8*k +: 8] = shadow[(rows[i].fAddr + k) % RamBytes];
                end
                rows[i].expFetch = w;
            end
        end
    endtask

    task automatic runRow(input int idx, input int pass);
        rowT   r;
        int    edges;
        int    active;
        int    dataAt;
        int    fetchAt;
        int    dataPulses;
        int    fetchPulses;
        int    k;
        wordT  heldLoad;
        ownerT lastOwner;
        ownerT seen[$];
        ownerT want[$];
        r = rows[idx];
        curRow = idx;
        rowBad = 1'b0;
        heldLoad = loadData;
        edges = 0;
        active = 0;
        dataAt = -1;
        fetchAt = -1;
        dataPulses = 0;
        fetchPulses = 0;
        lastOwner = ownerNone;
        fetchEn = r.useFetch;
        fetchAddr = r.fAddr;
        dataEn = r.useData;
        dataWrite = r.write;
        dataLen = r.len;
        dataAddr = r.dAddr;
        dataWData = r.wdata;
        rdy = nextRdy(pass);
        while ((r.useData && dataPulses == 0) || (r.useFetch && fetchPulses == 0)) begin
            @(posedge clk);
            edges++;
            if (rdy) begin
                active++;
            end
            #1;
            if (owner != lastOwner) begin
                seen.push_back(owner);
                lastOwner = owner;
            end
            rdy = nextRdy(pass);
            if (dataDone && dataAt < 0 && r.useData) begin
                dataAt = edges;
                dataEn = 1'b0;
                if (!r.useFetch) begin
                    countIs("dataDone latency", active + 1,
                        int'(r.len) + (r.write ? 2 : 3));
                end
                if (r.write) begin
                    compareWord("loadData", loadData, heldLoad);
                end else begin
                    compareWord("loadData", loadData, r.expData);
                    if (pass == 0) begin
                        gapFreeLoad[idx] = loadData;
                    end else begin
                        compareWord("loadData vs gap-free", loadData, gapFreeLoad[idx]);
                    end
                end
            end
            if (fetchDone && fetchAt < 0 && r.useFetch) begin
                fetchAt = edges;
                fetchEn = 1'b0;
                if (!r.useData) begin
                    countIs("fetchDone latency", active + 1, 7);
                end
                compareWord("fetchInst", fetchInst, r.expFetch);
                if (pass == 0) begin
                    gapFreeInst[idx] = fetchInst;
                end else begin
                    compareWord("fetchInst vs gap-free", fetchInst, gapFreeInst[idx]);
                end
            end
            // a pulse is taken in a cycle where rdy is high
            if (dataDone && rdy) begin
                dataPulses++;
            end
            if (fetchDone && rdy) begin
                fetchPulses++;
            end
        end
        countIs("dataDone pulses", dataPulses, r.useData ? 1 : 0);
        countIs("fetchDone pulses", fetchPulses, r.useFetch ? 1 : 0);
        if (r.useData && r.useFetch) begin
            doneOrder(dataAt, fetchAt);
        end
        rdy = 1'b1;
        repeat (2) begin
            @(posedge clk);
            #1;
            if (dataDone || fetchDone) begin
                $display("row %0d: a done pulse came again after it was taken", idx);
                errors++;
                rowBad = 1'b1;
            end
            if (owner != lastOwner) begin
                seen.push_back(owner);
                lastOwner = owner;
            end
        end
        if (r.useData) begin
            want.push_back(ownerData);
            want.push_back(ownerNone);
        end
        if (r.useFetch) begin
            want.push_back(ownerFetch);
            want.push_back(ownerNone);
        end
        countIs("owner changes", seen.size(), want.size());
        for (k = 0; k < want.size() && k < seen.size(); k++) begin
            ownerIs("owner", seen[k], want[k]);
        end
        rowsRun++;
        if (rowBad) begin
            failedRows++;
        end
        $display("row %0d pass %0d %s", idx, pass, rowBad ? "failed" : "ok");
    endtask

    initial begin
        int unsigned seed;
        int          pass;
        int          idx;
        seed = 32'h357d;
        void'($urandom(seed));
        rst = 1'b1;
        rdy = 1'b1;
        fetchEn = 1'b0;
        fetchAddr = '0;
        dataEn = 1'b0;
        dataWrite = 1'b0;
        dataLen = '0;
        dataAddr = '0;
        dataWData = '0;
        errors = 0;
        failedRows = 0;
        rowsRun = 0;
        curRow = 0;
        cycleCount = 0;
        gapPos = 0;
        stallCycles = 0;
        // roughly one stalled cycle in four
        for (idx = 0; idx < GapCycles; idx++) begin
            gapPattern[idx] = ($urandom % 4) != 0;
            if (!gapPattern[idx]) begin
                stallCycles++;
            end
        end
        cycleLimit = 2 * NumRows * RowCycles + ResetCycles + stallCycles;

        // fetch, data, write, len, data address, fetch address
        setRow(0, 1, 0, 0, 3'd4, 32'h000, 32'h010);
        setRow(1, 1, 0, 0, 3'd4, 32'h000, 32'h1fd);
        setRow(2, 0, 1, 0, 3'd1, 32'h021, 32'h000);
        setRow(3, 0, 1, 0, 3'd2, 32'h042, 32'h000);
        setRow(4, 0, 1, 0, 3'd4, 32'h060, 32'h000);
        setRow(5, 0, 1, 1, 3'd1, 32'h081, 32'h000);
        setRow(6, 0, 1, 0, 3'd4, 32'h080, 32'h000);
        setRow(7, 0, 1, 1, 3'd2, 32'h092, 32'h000);
        setRow(8, 0, 1, 0, 3'd4, 32'h090, 32'h000);
        setRow(9, 0, 1, 1, 3'd4, 32'h0a0, 32'h000);
        setRow(10, 0, 1, 0, 3'd4, 32'h0a0, 32'h000);
        setRow(11, 0, 1, 0, 3'd1, 32'h0a3, 32'h000);
        setRow(12, 1, 1, 0, 3'd2, 32'h0c2, 32'h0c0);
        setRow(13, 1, 1, 1, 3'd4, 32'h0e0, 32'h0e0);
        computeExpected();

        i_byteRamModel.preload();
        repeat (ResetCycles) @(posedge clk);
        #1;
        rst = 1'b0;

        for (pass = 0; pass < 2; pass++) begin
            i_byteRamModel.preload();
            gapPos = 0;
            for (idx = 0; idx < NumRows; idx++) begin
                runRow(idx, pass);
            end
        end

        $display("%0d rows run, %0d rows failed, %0d checks failed",
            rowsRun, failedRows, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- verilog.f
src/memCtrlPkg.sv
src/memXferIf.sv
src/memArbiter.sv
src/byteSequencer.sv
src/memResponse.sv
src/memCtrl.sv
test/byteRamModel.sv
test/memCtrlTb.sv
